// ==== source/scope_pkg.sv ====
`default_nettype none

// Shared types for the scope trigger and capture path

package scope_pkg;

    //////////////////////////////
    // Sample format
    //////////////////////////////

    // ADC code width
    localparam int SAMPLE_W = 12;

    // One unsigned ADC sample, zero code at the bottom of the range
    typedef logic [SAMPLE_W-1:0] sample_t;

    //////////////////////////////
    // Trigger setup
    //////////////////////////////

    // Edge that fires the trigger
    typedef enum logic {
        EDGE_RISING  = 1'b0,
        EDGE_FALLING = 1'b1
    } trig_edge_t;

    // Hysteresis FSM in the detector
    typedef enum logic {
        TRIG_WAIT_ARM   = 1'b0,  // Waiting to leave the band on the far side
        TRIG_WAIT_CROSS = 1'b1   // Waiting for the level crossing
    } trig_state_t;

    //////////////////////////////
    // Capture control
    //////////////////////////////

    typedef enum logic [1:0] {
        CAP_IDLE  = 2'd0,
        CAP_ARMED = 2'd1,
        CAP_FILL  = 2'd2,
        CAP_DONE  = 2'd3
    } cap_state_t;

endpackage

`default_nettype wire

// ==== source/trig_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Detector to capture link
interface trig_if;

    // Qualified sample stream
    scope_pkg::sample_t data;
    logic               valid;

    // First sample of the record, only with valid
    logic trigger;

    // Capture side is waiting for a trigger
    logic armed;

    // Trigger detector side
    modport detector (
        output data,
        output valid,
        output trigger,
        input  armed
    );

    // Capture memory side
    modport capture (
        input  data,
        input  valid,
        input  trigger,
        output armed
    );

endinterface

`default_nettype wire

// ==== source/sample_decimator.sv ====
`timescale 1ns/100ps
`default_nettype none

// Keeps one ADC sample out of every period plus one valid samples
module sample_decimator #(
    parameter int COARSE_STEP = 18
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire scope_pkg::sample_t adc_data,
    input  wire logic               adc_valid,
    input  wire logic [11:0]        decim_coarse,
    input  wire logic [11:0]        decim_fine,
    output scope_pkg::sample_t      dec_sample,
    output logic                    dec_valid
);

    //////////////////////////////
    // Period
    //////////////////////////////

    // Product width for coarse times step, one more bit for the fine add
    localparam int STEP_W = $clog2(COARSE_STEP + 1);
    localparam int PER_W  = 12 + STEP_W + 1;

    logic [PER_W-1:0] period;
    logic [PER_W-1:0] count;
    logic             hit;

    // Period straight from the static settings
    assign period = PER_W'(decim_coarse) * PER_W'(COARSE_STEP) + PER_W'(decim_fine);

    // Current valid sample is the one to keep
    assign hit = (count == period);

    //////////////////////////////
    // Counter and output
    //////////////////////////////

    // Count only advances on accepted samples
    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= adc_valid && hit;
            if (adc_valid) begin
                if (hit) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // Payload capture, qualified by dec_valid downstream
    always_ff @(posedge clk) begin
        if (adc_valid && hit) begin
            dec_sample <= adc_data;
        end
    end

    // Period settings hold still once out of reset
    assert property (@(posedge clk) disable iff (rst)
        $stable(decim_coarse) && $stable(decim_fine));

endmodule

`default_nettype wire

// ==== source/trigger_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

// Level trigger with hysteresis on the decimated stream
module trigger_detector #(
    parameter int HYST = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire scope_pkg::sample_t    dec_sample,
    input  wire logic                  dec_valid,
    input  wire scope_pkg::sample_t    trig_level,
    input  wire scope_pkg::trig_edge_t trig_edge,
    trig_if.detector                   trg
);

    //////////////////////////////
    // Signed compare values
    //////////////////////////////

    // Two extra bits, so level +/- HYST never wraps
    localparam int CMP_W = scope_pkg::SAMPLE_W + 2;

    logic signed [CMP_W-1:0] samp_s;
    logic signed [CMP_W-1:0] level_s;
    logic signed [CMP_W-1:0] band_lo;
    logic signed [CMP_W-1:0] band_hi;

    // Zero extend the unsigned codes
    assign samp_s  = $signed({2'b00, dec_sample});
    assign level_s = $signed({2'b00, trig_level});

    // Band below may go negative, band above may pass full scale
    assign band_lo = level_s - CMP_W'(HYST);
    assign band_hi = level_s + CMP_W'(HYST);

    //////////////////////////////
    // Edge qualifiers
    //////////////////////////////

    logic rising;
    logic arm_hit;
    logic cross_hit;

    assign rising = (trig_edge == scope_pkg::EDGE_RISING);

    // Far side of the band, opposite to the edge direction
    assign arm_hit = rising ? (samp_s <= band_lo) : (samp_s >= band_hi);

    // Reached or passed the level
    assign cross_hit = rising ? (samp_s >= level_s) : (samp_s <= level_s);

    //////////////////////////////
    // Hysteresis FSM
    //////////////////////////////

    scope_pkg::trig_state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= scope_pkg::TRIG_WAIT_ARM;
            trg.valid   <= 1'b0;
            trg.trigger <= 1'b0;
        end else begin
            // Stream passes through one cycle late
            trg.valid   <= dec_valid;
            trg.trigger <= 1'b0;
            if (!trg.armed) begin
                // Start over every time capture is not waiting
                state <= scope_pkg::TRIG_WAIT_ARM;
            end else if (dec_valid) begin
                case (state)
                    scope_pkg::TRIG_WAIT_ARM: begin
                        if (arm_hit) begin
                            state <= scope_pkg::TRIG_WAIT_CROSS;
                        end
                    end
                    scope_pkg::TRIG_WAIT_CROSS: begin
                        // Fire on this very sample
                        if (cross_hit) begin
                            trg.trigger <= 1'b1;
                            state       <= scope_pkg::TRIG_WAIT_ARM;
                        end
                    end
                    default: begin
                        state <= scope_pkg::TRIG_WAIT_ARM;
                    end
                endcase
            end
        end
    end

    // Sample kept alongside valid and trigger
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            trg.data <= dec_sample;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Trigger lands on a real sample while capture still waits for it
    assert property (@(posedge clk) disable iff (rst)
        trg.trigger |-> (trg.valid && trg.armed));

endmodule

`default_nettype wire

// ==== source/capture_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Arm/fill/done control with the record memory and read port
module capture_buffer #(
    parameter int DEPTH = 256
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       arm,
    input  wire logic [$clog2(DEPTH)-1:0]   rd_addr,
    output scope_pkg::sample_t              rd_data,
    output logic                            capture_busy,
    output logic                            capture_done,
    trig_if.capture                         trg
);

    localparam int AW = $clog2(DEPTH);

    scope_pkg::cap_state_t state;
    logic [AW-1:0]         wr_addr;
    logic                  mem_we;
    logic                  last;

    // Record storage
    scope_pkg::sample_t mem [DEPTH];

    //////////////////////////////
    // Status decode
    //////////////////////////////

    assign trg.armed    = (state == scope_pkg::CAP_ARMED);
    assign capture_busy = (state == scope_pkg::CAP_ARMED) || (state == scope_pkg::CAP_FILL);
    assign capture_done = (state == scope_pkg::CAP_DONE);

    // Trigger sample goes to 0, then each valid one after it
    assign mem_we = (state == scope_pkg::CAP_ARMED && trg.trigger) ||
                    (state == scope_pkg::CAP_FILL && trg.valid);

    // Write at the top address ends the record
    assign last = (wr_addr == AW'(DEPTH - 1));

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= scope_pkg::CAP_IDLE;
            wr_addr <= '0;
        end else begin
            if (mem_we) begin
                wr_addr <= wr_addr + 1'b1;
            end
            case (state)
                scope_pkg::CAP_IDLE, scope_pkg::CAP_DONE: begin
                    if (arm) begin
                        state   <= scope_pkg::CAP_ARMED;
                        wr_addr <= '0;
                    end
                end
                scope_pkg::CAP_ARMED: begin
                    // Arm pulses here are ignored
                    if (trg.trigger) begin
                        state <= last ? scope_pkg::CAP_DONE : scope_pkg::CAP_FILL;
                    end
                end
                scope_pkg::CAP_FILL: begin
                    if (trg.valid && last) begin
                        state <= scope_pkg::CAP_DONE;
                    end
                end
                default: begin
                    state <= scope_pkg::CAP_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Memory
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[wr_addr] <= trg.data;
        end
    end

    // Registered read, open in every state
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Trigger write lands at 0, fill writes never wrap back to it
    assert property (@(posedge clk) disable iff (rst)
        mem_we |-> ((state == scope_pkg::CAP_ARMED) == (wr_addr == '0)));

    // Done only follows the write at the top address
    assert property (@(posedge clk) disable iff (rst)
        $rose(capture_done) |-> $past(mem_we && last));

endmodule

`default_nettype wire

// ==== source/scope_trigger_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// Scope trigger and capture path, decimator to detector to record memory
module scope_trigger_top #(
    parameter int COARSE_STEP = 18,
    parameter int HYST        = 8,
    parameter int DEPTH       = 256
) (
    input  wire logic                      clk,
    input  wire logic                      rst,

    // ADC stream
    input  wire scope_pkg::sample_t        adc_data,
    input  wire logic                      adc_valid,

    // Decimation setup, held while out of reset
    input  wire logic [11:0]               decim_coarse,
    input  wire logic [11:0]               decim_fine,

    // Trigger setup
    input  wire scope_pkg::sample_t        trig_level,
    input  wire scope_pkg::trig_edge_t     trig_edge,
    input  wire logic                      arm,

    // Record readback
    input  wire logic [$clog2(DEPTH)-1:0]  rd_addr,
    output scope_pkg::sample_t             rd_data,
    output logic                           capture_busy,
    output logic                           capture_done
);

    //////////////////////////////
    // Internal links
    //////////////////////////////

    // Decimated stream
    scope_pkg::sample_t dec_sample;
    logic               dec_valid;

    // Detector to capture
    trig_if trg ();

    //////////////////////////////
    // Blocks
    //////////////////////////////

    sample_decimator #(
        .COARSE_STEP (COARSE_STEP)
    ) u_decimator (
        .clk          (clk),
        .rst          (rst),
        .adc_data     (adc_data),
        .adc_valid    (adc_valid),
        .decim_coarse (decim_coarse),
        .decim_fine   (decim_fine),
        .dec_sample   (dec_sample),
        .dec_valid    (dec_valid)
    );

    trigger_detector #(
        .HYST (HYST)
    ) u_detector (
        .clk        (clk),
        .rst        (rst),
        .dec_sample (dec_sample),
        .dec_valid  (dec_valid),
        .trig_level (trig_level),
        .trig_edge  (trig_edge),
        .trg        (trg.detector)
    );

    capture_buffer #(
        .DEPTH (DEPTH)
    ) u_capture (
        .clk          (clk),
        .rst          (rst),
        .arm          (arm),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .capture_busy (capture_busy),
        .capture_done (capture_done),
        .trg          (trg.capture)
    );

endmodule

`default_nettype wire

// ==== bench/scope_ref.svh ====
`ifndef SCOPE_REF_SVH
`define SCOPE_REF_SVH
`default_nettype none

//////////////////////////////
// Reference model over log_q
//////////////////////////////

// Decimator keeps the sample where the count since reset reaches the period
function automatic bit decim_keep(input int idx, input int per);
    return (idx % (per + 1)) == per;
endfunction

// Hysteresis search on kept samples from start, log index of the trigger or -1
function automatic int find_trigger(input int start, input int per, input int level,
                                    input scope_pkg::trig_edge_t edge_sel, input int hyst);
    scope_pkg::trig_state_t st;
    bit                     falling;
    int                     s;
    int                     i;
    st      = scope_pkg::TRIG_WAIT_ARM;
    falling = (edge_sel == scope_pkg::EDGE_FALLING);
    for (i = start; i < log_q.size(); i++) begin
        if (decim_keep(i, per)) begin
            s = int'(log_q[i]);
            if (st == scope_pkg::TRIG_WAIT_ARM) begin
                // Far side of the band first
                if (falling ? (s >= level + hyst) : (s <= level - hyst)) begin
                    st = scope_pkg::TRIG_WAIT_CROSS;
                end
            end else if (falling ? (s <= level) : (s >= level)) begin
                return i;
            end
        end
    end
    return -1;
endfunction

// Trigger sample then the kept samples after it, into exp_q
function automatic int expected_record(input int start, input int per, input int level,
                                       input scope_pkg::trig_edge_t edge_sel,
                                       input int hyst, output int trig_at);
    int i;
    exp_q.delete();
    trig_at = find_trigger(start, per, level, edge_sel, hyst);
    if (trig_at >= 0) begin
        exp_q.push_back(log_q[trig_at]);
        for (i = trig_at + 1; i < log_q.size() && exp_q.size() < TB_DEPTH; i++) begin
            if (decim_keep(i, per)) begin
                exp_q.push_back(log_q[i]);
            end
        end
    end
    return exp_q.size();
endfunction

`default_nettype wire
`endif

// ==== bench/scope_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

// Testbench for the scope trigger and capture path
module scope_tb;

    localparam int  TB_STEP    = 18;
    localparam int  TB_HYST    = 8;
    localparam int  TB_DEPTH   = 64;
    localparam int  ADDR_W     = $clog2(TB_DEPTH);
    localparam int  WAVE_SINE  = 0;
    localparam int  WAVE_WOBBLE = 1;
    localparam int  WOBBLE_LEN = 200;
    localparam int  WOBBLE_AMP = 6;
    localparam real PI         = 3.14159265358979;

    logic                  clk;
    logic                  rst;
    scope_pkg::sample_t    adc_data;
    logic                  adc_valid;
    logic [11:0]           decim_coarse;
    logic [11:0]           decim_fine;
    scope_pkg::sample_t    trig_level;
    scope_pkg::trig_edge_t trig_edge;
    logic                  arm;
    logic [ADDR_W-1:0]     rd_addr;
    scope_pkg::sample_t    rd_data;
    logic                  capture_busy;
    logic                  capture_done;

    // Every valid sample since reset, and the expected record
    scope_pkg::sample_t log_q [$];
    scope_pkg::sample_t exp_q [$];

    int                 seed;
    int                 period;
    int                 start_idx;
    int                 error_count;
    int                 timeout_count;
    scope_pkg::sample_t first_word;
    logic               rd_on;
    logic               chk_on;
    int                 chk_addr;

    scope_trigger_top #(
        .COARSE_STEP (TB_STEP),
        .HYST        (TB_HYST),
        .DEPTH       (TB_DEPTH)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .adc_data     (adc_data),
        .adc_valid    (adc_valid),
        .decim_coarse (decim_coarse),
        .decim_fine   (decim_fine),
        .trig_level   (trig_level),
        .trig_edge    (trig_edge),
        .arm          (arm),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .capture_busy (capture_busy),
        .capture_done (capture_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Ramp plus sine, or a narrow wobble before a real swing
    function automatic int wave_sample(input int mode, input int n, input int level);
        int v;
        if (mode == WAVE_WOBBLE && n < WOBBLE_LEN) begin
            // Stays inside the band, never far enough to arm
            case (n % 4)
                0: v = level - WOBBLE_AMP;
                1: v = level - 2;
                2: v = level + 3;
                default: v = level + WOBBLE_AMP;
            endcase
        end else if (mode == WAVE_WOBBLE) begin
            v = level + int'(800.0 * $sin(2.0 * PI * real'(n - WOBBLE_LEN) / 50.0 - PI / 2.0));
        end else begin
            v = 2048 + int'(1400.0 * $sin(2.0 * PI * real'(n) / 50.0)) + 3 * (n % 100);
        end
        if (v < 0) begin
            v = 0;
        end
        if (v > 4095) begin
            v = 4095;
        end
        return v;
    endfunction

    // Settings only move while rst is high
    task automatic apply_reset(input int coarse, input int fine);
        @(posedge clk);
        #1;
        rst          = 1'b1;
        adc_valid    = 1'b0;
        arm          = 1'b0;
        decim_coarse = 12'(coarse);
        decim_fine   = 12'(fine);
        period       = coarse * TB_STEP + fine;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        log_q.delete();
    endtask

    // Idle input, pipeline drain, arm pulse, then wait for busy
    task automatic arm_capture(output bit ok);
        int t;
        adc_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arm = 1'b1;
        @(posedge clk);
        #1;
        arm = 1'b0;
        ok  = 1'b0;
        for (t = 0; t < 20; t++) begin
            if (capture_busy) begin
                ok = 1'b1;
                break;
            end
            @(posedge clk);
            #1;
        end
        if (!ok) begin
            timeout_count++;
            $display("Timeout: capture_busy did not rise after arm");
        end
        assert (!capture_done) else begin
            error_count++;
            $display("** Error at %0t: capture_done expected 0 got 1 after arm", $time);
        end
        start_idx = log_q.size();
    endtask

    // Feed the waveform until the record is complete
    task automatic drive_until_done(input int mode, input int level, input bit gaps,
                                    input bit rearm, input int limit, output bit ok);
        int cyc;
        int n;
        ok = 1'b0;
        n  = 0;
        for (cyc = 0; cyc < limit; cyc++) begin
            @(posedge clk);
            #1;
            if (capture_done) begin
                ok = 1'b1;
                break;
            end
            // Extra arm pulses fall inside the fill
            arm = rearm && (cyc == 20 || cyc == 45);
            if (gaps && (($random(seed) & 3) == 0)) begin
                adc_valid = 1'b0;
            end else begin
                adc_data  = scope_pkg::sample_t'(wave_sample(mode, n, level));
                adc_valid = 1'b1;
                log_q.push_back(adc_data);
                n++;
            end
        end
        adc_valid = 1'b0;
        arm       = 1'b0;
        if (!ok) begin
            timeout_count++;
            $display("Timeout: capture_done did not rise within %0d cycles", limit);
        end
    endtask

    // Steps rd_addr, the compare process checks one cycle later
    task automatic read_record();
        int a;
        for (a = 0; a < TB_DEPTH; a++) begin
            @(posedge clk);
            #1;
            rd_addr = ADDR_W'(a);
            rd_on   = 1'b1;
        end
        @(posedge clk);
        #1;
        rd_on = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    // Single word through the registered read port
    task automatic read_word(input int addr, output scope_pkg::sample_t data);
        rd_addr = ADDR_W'(addr);
        @(posedge clk);
        #1;
        data = rd_data;
    endtask

    task automatic capture_and_check(input int mode, input int level,
                                     input scope_pkg::trig_edge_t edge_sel,
                                     input bit gaps, input bit rearm);
        bit ok;
        int got;
        int trig_pos;
        trig_pos   = -1;
        trig_level = scope_pkg::sample_t'(level);
        trig_edge  = edge_sel;
        arm_capture(ok);
        if (ok) begin
            drive_until_done(mode, level, gaps, rearm, gaps ? 20000 : 4000, ok);
        end
        if (ok) begin
            got = expected_record(start_idx, period, level, edge_sel, TB_HYST, trig_pos);
            assert (got == TB_DEPTH) else begin
                error_count++;
                $display("Model found only %0d of %0d record samples, trigger index %0d",
                         got, TB_DEPTH, trig_pos);
            end
            read_record();
        end
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////

    // rd_data read at the edge holds the word for last cycle's address
    always @(posedge clk) begin
        if (chk_on) begin
            assert (rd_data == exp_q[chk_addr]) else begin
                error_count++;
                $display("** Error at %0t: address %0d expected 0x%03h got 0x%03h",
                         $time, chk_addr, exp_q[chk_addr], rd_data);
            end
        end
        chk_on   = rd_on;
        chk_addr = int'(rd_addr);
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        seed          = 32'h41b1;
        error_count   = 0;
        timeout_count = 0;
        rst           = 1'b1;
        adc_data      = '0;
        adc_valid     = 1'b0;
        decim_coarse  = '0;
        decim_fine    = '0;
        trig_level    = '0;
        trig_edge     = scope_pkg::EDGE_RISING;
        arm           = 1'b0;
        rd_addr       = '0;
        rd_on         = 1'b0;
        chk_on        = 1'b0;
        chk_addr      = 0;
        first_word    = '0;

        // Quiet outputs after reset, no decimation
        apply_reset(0, 0);
        assert (!capture_busy && !capture_done) else begin
            error_count++;
            $display("** Error at %0t: busy/done expected 0/0 got %0b/%0b",
                     $time, capture_busy, capture_done);
        end

        // Rising edge, record opens at or above the level
        capture_and_check(WAVE_SINE, 2600, scope_pkg::EDGE_RISING, 1'b0, 1'b0);
        read_word(0, first_word);
        assert (first_word >= 12'd2600) else begin
            error_count++;
            $display("** Error at %0t: record start expected at or above 2600 got %0d",
                     $time, first_word);
        end

        // Falling edge at another level
        capture_and_check(WAVE_SINE, 1700, scope_pkg::EDGE_FALLING, 1'b0, 1'b0);

        // Wobble inside the band must not trigger
        capture_and_check(WAVE_WOBBLE, 2200, scope_pkg::EDGE_RISING, 1'b0, 1'b0);
        read_word(0, first_word);
        assert (first_word > 12'(2200 + WOBBLE_AMP)) else begin
            error_count++;
            $display("** Error at %0t: record start %0d lies inside the wobble band",
                     $time, first_word);
        end

        // Arm pulses during fill, then re-arm from done
        capture_and_check(WAVE_SINE, 2600, scope_pkg::EDGE_RISING, 1'b0, 1'b1);
        assert (capture_done) else begin
            error_count++;
            $display("** Error at %0t: capture_done expected 1 got 0", $time);
        end
        capture_and_check(WAVE_SINE, 2300, scope_pkg::EDGE_FALLING, 1'b0, 1'b0);

        // Period 21 with random input gaps
        apply_reset(1, 3);
        capture_and_check(WAVE_SINE, 2048, scope_pkg::EDGE_RISING, 1'b1, 1'b0);

        $display("Run finished: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    `include "scope_ref.svh"

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+bench
source/scope_pkg.sv
source/trig_if.sv
source/sample_decimator.sv
source/trigger_detector.sv
source/capture_buffer.sv
source/scope_trigger_top.sv
bench/scope_tb.sv

// ==== Makefile ====
# Verilator build and run for the scope trigger testbench

VERILATOR ?= verilator
TB_TOP    ?= scope_tb
RTL_TOP   ?= scope_trigger_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only when the exact pass line shows up in the log
run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
